// ==== compile.f ====
+incdir+logic
logic/decode_pkg.sv
logic/regFile.sv
logic/branchResolve.sv
logic/decodeStage.sv
logic/pcCounter.sv
logic/haltControl.sv
logic/decodeTop.sv
dv/decode_assert.sv
dv/decode_tb.sv

// ==== dv/decode_assert.sv ====
// **************************************************
// Bound checks on halt, PC stepping and pcSel
// **************************************************
`include "decode_params.svh"

module decode_assert (
   input logic                   clk,
   input logic                   rst,
   input decode_pkg::ctrlFlags_t ctrl,
   input logic                   pcSel,
   input logic [`DATA_W-1:0]     pc,
   input logic                   halted
);

   // The halting instruction never redirects
   haltBlocksBranch: assert property (@(posedge clk) !rst && ctrl.halt |-> !pcSel)
      else $error("pcSel is high on a halting instruction");

   // Counter frozen after halt
   pcFrozen: assert property (@(posedge clk) !rst && halted |=> $stable(pc))
      else $error("pc moved while halted");

   // Only reset leaves HALTED
   haltSticky: assert property (@(posedge clk) !rst && halted |=> halted)
      else $error("halted dropped without reset");

   // Sequential step while running, running being the inverse of halted
   pcSteps: assert property (@(posedge clk) !rst && !halted && !pcSel
                             |=> pc == $past(pc) + `DATA_W'(`PC_STEP))
      else $error("pc did not step by one word");

endmodule

bind decodeTop decode_assert uDecodeAssert (
   .clk    (clk),
   .rst    (rst),
   .ctrl   (ctrl),
   .pcSel  (pcSel),
   .pc     (pc),
   .halted (halted)
);

// ==== dv/decode_input.txt ====
# Columns: instr imm writeAddr writeback (hex), lbi link writeEn bFlag jFlag halt (binary),
# expected pcSel (binary). One line per clock cycle after reset.
A020 0000 0 0000 0 0 0 0 0 0 0
A260 0000 0 0000 0 0 0 0 0 0 0
A4A0 0000 0 0000 0 0 0 0 0 0 0
A6E0 0000 0 0000 0 0 0 0 0 0 0
A000 0000 1 1234 0 0 1 0 0 0 0
A000 FFF0 2 DEAD 1 0 1 0 0 0 0
A000 0000 3 BEEF 0 1 1 0 0 0 0
A140 0000 0 0000 0 0 0 0 0 0 0
A360 0000 0 0000 0 0 0 0 0 0 0
A000 0005 5 0000 1 0 1 0 0 0 0
6000 0010 0 0000 0 0 0 0 0 0 1
6200 0010 0 0000 0 0 0 0 0 0 0
6100 0010 0 0000 0 0 0 0 0 0 0
6800 0008 0 0000 0 0 0 0 0 0 0
6A00 FFFC 0 0000 0 0 0 0 0 0 1
6900 0006 0 0000 0 0 0 0 0 0 1
7000 0010 0 0000 0 0 0 0 0 0 0
7200 0004 0 0000 0 0 0 0 0 0 1
7100 0010 0 0000 0 0 0 0 0 0 0
7800 000C 0 0000 0 0 0 0 0 0 1
7A00 0010 0 0000 0 0 0 0 0 0 0
7900 FFF8 0 0000 0 0 0 0 0 0 1
E000 0020 0 0000 0 0 0 1 1 0 1
E000 0040 6 0000 0 1 1 1 1 0 1
A6C0 0000 0 0000 0 0 0 0 0 0 0
A000 0030 0 0000 0 0 0 0 1 0 0
A800 0030 0 0000 0 0 0 1 0 0 0
6000 0010 7 7777 0 0 1 0 0 1 0
A7E0 0000 0 0000 0 0 0 0 0 0 0
A000 0000 1 AAAA 0 0 1 0 0 0 0
A120 0000 0 0000 0 0 0 0 0 0 0
6000 0010 0 0000 0 0 0 0 0 0 1
A2E0 0000 0 0000 0 0 0 0 0 0 0

// ==== dv/decode_tb.sv ====
// **************************************************
// Testbench for the decode top level, file-driven
// with a register and PC reference model
// **************************************************
`include "decode_params.svh"

module decode_tb;

   localparam int RESET_CYCLES   = 10;
   localparam int TIMEOUT_MARGIN = 50;  // Spare cycles beyond the vector count

   logic                   clk;
   logic                   rst;
   logic [`DATA_W-1:0]     instr;
   logic [`DATA_W-1:0]     imm;
   decode_pkg::regWrite_t  wr;
   decode_pkg::ctrlFlags_t ctrl;
   logic [`DATA_W-1:0]     reg1Data;
   logic [`DATA_W-1:0]     reg2Data;
   logic                   pcSel;
   logic [`DATA_W-1:0]     pc;
   logic                   halted;

   // One entry per line of the stimulus file
   logic [`DATA_W-1:0]     vecInstr [$];
   logic [`DATA_W-1:0]     vecImm [$];
   decode_pkg::regWrite_t  vecWr [$];
   decode_pkg::ctrlFlags_t vecCtrl [$];
   logic                   vecSel [$];  // Expected pcSel from the file

   // Reference model state
   logic [`DATA_W-1:0]     mRegs [`NUM_REGS];
   logic [`DATA_W-1:0]     mPc;
   logic [`DATA_W-1:0]     mPcInstr;  // PC of the instruction in decode
   logic                   mHalted;

   // Inputs now applied, taken by the model at the next edge
   logic [`DATA_W-1:0]     curInstr;
   logic [`DATA_W-1:0]     curImm;
   decode_pkg::regWrite_t  curWr;
   decode_pkg::ctrlFlags_t curCtrl;

   int cycleCount = 0;
   int cycleLimit = 0;  // Set once the file is read

   decodeTop u_dut (
      .clk      (clk),
      .rst      (rst),
      .instr    (instr),
      .imm      (imm),
      .wr       (wr),
      .ctrl     (ctrl),
      .reg1Data (reg1Data),
      .reg2Data (reg2Data),
      .pcSel    (pcSel),
      .pc       (pc),
      .halted   (halted)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("Test failures found");
      $fatal(1, "Run stopped");
   endtask

   task automatic reportMismatch(input string name, input logic [`DATA_W-1:0] expVal,
                                 input logic [`DATA_W-1:0] actVal);
      abortRun($sformatf("CHECK FAILED at time %0t: %s expected %h, got %h",
                         $time, name, expVal, actVal));
   endtask

   // Branch rule taken straight from the instruction fields and Rs
   function automatic logic modelPcSel(input logic [`DATA_W-1:0] ins,
                                       input decode_pkg::ctrlFlags_t flags);
      logic [`DATA_W-1:0] rsVal;
      logic               isBranch;
      logic               condMet;
      rsVal    = mRegs[ins[10:8]];
      isBranch = (ins[15:13] == decode_pkg::OP_BRANCH) || flags.bFlag;
      case (decode_pkg::branchCond_e'(ins[12:11]))
         decode_pkg::BEQZ: condMet = (rsVal == '0);
         decode_pkg::BNEZ: condMet = (rsVal != '0);
         decode_pkg::BLTZ: condMet = rsVal[`DATA_W-1];   // Negative
         default:          condMet = !rsVal[`DATA_W-1];  // BGEZ
      endcase
      return isBranch && !flags.halt && (condMet || flags.jFlag);
   endfunction

   task automatic loadVectors();
      int                 fd;
      int                 count;
      int                 lineNo;
      string              line;
      logic [`DATA_W-1:0] fInstr;
      logic [`DATA_W-1:0] fImm;
      logic [`DATA_W-1:0] fWb;
      logic [2:0]         fWa;
      logic               fLbi, fLink, fWe, fBf, fJf, fHalt, fSel;
      lineNo = 0;
      fd = $fopen("dv/decode_input.txt", "r");
      if (fd == 0) begin
         abortRun("Could not open the stimulus file dv/decode_input.txt");
      end
      while ($fgets(line, fd) != 0) begin
         lineNo++;
         if (line.len() > 1 && line.getc(0) != "#") begin  // Skip blanks and comments
            count = $sscanf(line, "%h %h %h %h %b %b %b %b %b %b %b", fInstr, fImm, fWa,
                            fWb, fLbi, fLink, fWe, fBf, fJf, fHalt, fSel);
            if (count != 11) begin
               abortRun($sformatf("Line %0d of the stimulus file is malformed", lineNo));
            end
            vecInstr.push_back(fInstr);
            vecImm.push_back(fImm);
            vecWr.push_back('{writeAddr: fWa, writeback: fWb});
            vecCtrl.push_back('{lbi: fLbi, link: fLink, writeEn: fWe, bFlag: fBf,
                                jFlag: fJf, halt: fHalt});
            vecSel.push_back(fSel);
         end
      end
      $fclose(fd);
   endtask

   // Model state after one clock edge with the current inputs
   task automatic advanceModel();
      logic               sel;
      logic [`DATA_W-1:0] wdata;
      logic [`DATA_W-1:0] nextPc;
      sel    = modelPcSel(curInstr, curCtrl);
      nextPc = mPc;  // Frozen once halted
      if (!mHalted) begin
         if (curCtrl.writeEn) begin
            if (curCtrl.link) wdata = mPcInstr + `DATA_W'(`PC_STEP);  // Return address
            else if (curCtrl.lbi) wdata = curImm;
            else wdata = curWr.writeback;
            mRegs[curWr.writeAddr] = wdata;
         end
         nextPc = sel ? mPcInstr + `DATA_W'(`PC_STEP) + curImm : mPc + `DATA_W'(`PC_STEP);
      end
      mPcInstr = mPc;
      mPc      = nextPc;
      if (curCtrl.halt) mHalted = 1'b1;
   endtask

   task automatic checkOutputs(input int idx);
      logic expSel;
      expSel = modelPcSel(curInstr, curCtrl);
      if (idx >= 0) begin  // Index -1 is the reset check with no file line
         assert (pcSel === vecSel[idx])
            else reportMismatch("pcSel (file)", `DATA_W'(vecSel[idx]), `DATA_W'(pcSel));
      end
      assert (pcSel === expSel) else reportMismatch("pcSel", `DATA_W'(expSel), `DATA_W'(pcSel));
      assert (pc === mPc) else reportMismatch("pc", mPc, pc);
      assert (halted === mHalted)
         else reportMismatch("halted", `DATA_W'(mHalted), `DATA_W'(halted));
      assert (reg1Data === mRegs[curInstr[10:8]])
         else reportMismatch("reg1Data", mRegs[curInstr[10:8]], reg1Data);
      assert (reg2Data === mRegs[curInstr[7:5]])
         else reportMismatch("reg2Data", mRegs[curInstr[7:5]], reg2Data);
   endtask

   // Limit covers reset, every vector and a margin
   initial begin
      while (cycleLimit == 0 || cycleCount < cycleLimit) begin
         @(posedge clk);
         cycleCount++;
      end
      abortRun($sformatf("Timeout: the run did not finish within %0d cycles", cycleLimit));
   end

   initial begin
      rst      = 1'b1;
      instr    = '0;
      imm      = '0;
      wr       = '0;
      ctrl     = '0;
      curInstr = '0;
      curImm   = '0;
      curWr    = '0;
      curCtrl  = '0;
      for (int r = 0; r < `NUM_REGS; r++) mRegs[r] = '0;
      mPc      = `DATA_W'(`RESET_PC);
      mPcInstr = `DATA_W'(`RESET_PC);
      mHalted  = 1'b0;
      loadVectors();
      cycleLimit = RESET_CYCLES + vecInstr.size() + TIMEOUT_MARGIN;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      checkOutputs(-1);  // Reset values of pc, halted and r0
      for (int i = 0; i < vecInstr.size(); i++) begin
         @(posedge clk);
         advanceModel();
         instr    <= vecInstr[i];
         imm      <= vecImm[i];
         wr       <= vecWr[i];
         ctrl     <= vecCtrl[i];
         curInstr = vecInstr[i];
         curImm   = vecImm[i];
         curWr    = vecWr[i];
         curCtrl  = vecCtrl[i];
         @(negedge clk);  // Outputs settled mid-cycle
         checkOutputs(i);
      end
      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== logic/branchResolve.sv ====
// **************************************************
// Branch condition check on Rs and PC-select strobe
// **************************************************
`include "decode_params.svh"

module branchResolve (
   input  logic [`DATA_W-1:0]     instr,
   input  logic [`DATA_W-1:0]     rsData,  // Contents of the first source register
   input  decode_pkg::ctrlFlags_t ctrl,
   output logic                   pcSel    // Load the branch target at the next edge
);

   decode_pkg::opGroup_e    opGroup;
   decode_pkg::branchCond_e cond;
   logic                    zeroFlag;
   logic                    signFlag;
   logic                    condTaken;
   logic                    branchFlag;

   // Opcode group and condition fields of the instruction
   assign opGroup = decode_pkg::opGroup_e'(instr[15:13]);
   assign cond    = decode_pkg::branchCond_e'(instr[12:11]);

   // Flags of Rs used by all four conditions
   assign zeroFlag = (rsData == '0);
   assign signFlag = rsData[`DATA_W-1];  // Two's complement sign

   always_comb begin
      condTaken = 1'b0;
      case (cond)
         decode_pkg::BEQZ: condTaken = zeroFlag;   // Rs == 0
         decode_pkg::BNEZ: condTaken = ~zeroFlag;  // Rs != 0
         decode_pkg::BLTZ: condTaken = signFlag;   // Rs < 0
         decode_pkg::BGEZ: condTaken = ~signFlag;  // Rs >= 0
         default:          condTaken = 1'b0;
      endcase
   end

   // Branch group from the opcode, or the path forced by the upstream decoder
   assign branchFlag = (opGroup == decode_pkg::OP_BRANCH) | ctrl.bFlag;

   // A jump skips the condition but still needs the branch path
   // The halting instruction never redirects the PC
   assign pcSel = branchFlag & ~ctrl.halt & (condTaken | ctrl.jFlag);

endmodule

// ==== logic/decodeStage.sv ====
// **************************************************
// Decode stage with register reads, write-data select
// and branch resolution
// **************************************************
`include "decode_params.svh"

module decodeStage (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`DATA_W-1:0]     instr,
   input  logic [`DATA_W-1:0]     imm,           // Sign-extended immediate
   input  logic [`DATA_W-1:0]     pc,            // Current fetch PC
   input  decode_pkg::regWrite_t  wr,
   input  decode_pkg::ctrlFlags_t ctrl,
   input  logic                   running,       // Low once halted
   output logic [`DATA_W-1:0]     reg1Data,
   output logic [`DATA_W-1:0]     reg2Data,
   output logic                   pcSel,
   output logic [`DATA_W-1:0]     branchTarget
);

   logic [`REG_ADDR_W-1:0] rs;
   logic [`REG_ADDR_W-1:0] rt;
   logic [`DATA_W-1:0]     pcInstr;
   logic [`DATA_W-1:0]     linkAddr;
   logic [`DATA_W-1:0]     writeData;
   logic                   regWriteEn;

   // Source register fields
   assign rs = instr[10:8];
   assign rt = instr[7:5];

   // PC of the instruction now in decode, one cycle behind the fetch PC
   always_ff @(posedge clk) begin
      if (rst) begin
         pcInstr <= `DATA_W'(`RESET_PC);
      end else begin
         pcInstr <= pc;
      end
   end

   // Return address and branch target share the pcInstr plus step term
   assign linkAddr     = pcInstr + `DATA_W'(`PC_STEP);
   assign branchTarget = linkAddr + imm;

   // Link wins over the immediate, which wins over writeback
   always_comb begin
      if (ctrl.link) begin
         writeData = linkAddr;
      end else if (ctrl.lbi) begin
         writeData = imm;
      end else begin
         writeData = wr.writeback;
      end
   end

   assign regWriteEn = ctrl.writeEn & running;  // No writes after halt

   regFile uRegFile (
      .clk       (clk),
      .rst       (rst),
      .readAddr1 (rs),
      .readAddr2 (rt),
      .writeEn   (regWriteEn),
      .writeAddr (wr.writeAddr),
      .writeData (writeData),
      .readData1 (reg1Data),
      .readData2 (reg2Data)
   );

   // Conditions are always tested on Rs
   branchResolve uBranchResolve (
      .instr  (instr),
      .rsData (reg1Data),
      .ctrl   (ctrl),
      .pcSel  (pcSel)
   );

endmodule

// ==== logic/decodeTop.sv ====
// **************************************************
// Top level joining halt control, PC counter and
// the decode stage
// **************************************************
`include "decode_params.svh"

module decodeTop (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`DATA_W-1:0]     instr,
   input  logic [`DATA_W-1:0]     imm,
   input  decode_pkg::regWrite_t  wr,        // Write address and writeback value
   input  decode_pkg::ctrlFlags_t ctrl,      // Sampled every cycle
   output logic [`DATA_W-1:0]     reg1Data,
   output logic [`DATA_W-1:0]     reg2Data,
   output logic                   pcSel,
   output logic [`DATA_W-1:0]     pc,
   output logic                   halted
);

   logic               running;
   logic [`DATA_W-1:0] branchTarget;

   haltControl uHaltControl (
      .clk     (clk),
      .rst     (rst),
      .halt    (ctrl.halt),
      .running (running),
      .halted  (halted)
   );

   pcCounter uPcCounter (
      .clk          (clk),
      .rst          (rst),
      .running      (running),
      .pcSel        (pcSel),
      .branchTarget (branchTarget),
      .pc           (pc)
   );

   decodeStage uDecodeStage (
      .clk          (clk),
      .rst          (rst),
      .instr        (instr),
      .imm          (imm),
      .pc           (pc),
      .wr           (wr),
      .ctrl         (ctrl),
      .running      (running),
      .reg1Data     (reg1Data),
      .reg2Data     (reg2Data),
      .pcSel        (pcSel),
      .branchTarget (branchTarget)
   );

endmodule

// ==== logic/decode_params.svh ====
// **************************************************
// Widths, register count and PC constants shared by
// the decode stage and its control blocks
// **************************************************
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Data path and program counter width
`define DATA_W 16

// Register index width and register count
`define REG_ADDR_W 3
`define NUM_REGS 8

// Program counter value after reset
`define RESET_PC 0

// Sequential increment, one 16-bit instruction word
`define PC_STEP 2

`endif

// ==== logic/decode_pkg.sv ====
// **************************************************
// Shared types for the decode stage, its control
// blocks and the testbench
// **************************************************
`include "decode_params.svh"

package decode_pkg;

   // Instruction group in bits 15..13
   // Only the branch group is decoded in this stage
   typedef enum logic [2:0] {
      OP_SYS    = 3'b000,  // Halt, nop and other system codes
      OP_IMM    = 3'b001,  // ALU with immediate
      OP_MEM    = 3'b010,  // Loads and stores
      OP_BRANCH = 3'b011,  // Conditional branches on Rs
      OP_LBI    = 3'b100,  // Load byte immediate family
      OP_ALU    = 3'b101,  // Register to register ALU
      OP_SHIFT  = 3'b110,  // Shifts and rotates
      OP_JUMP   = 3'b111   // Direct and register jumps
   } opGroup_e;

   // Branch condition in bits 12..11, always tested on Rs
   typedef enum logic [1:0] {
      BEQZ = 2'b00,  // Rs equal to zero
      BNEZ = 2'b01,  // Rs not zero
      BLTZ = 2'b10,  // Rs negative
      BGEZ = 2'b11   // Rs zero or positive
   } branchCond_e;

   // Run/halt control states
   typedef enum logic {
      RUN    = 1'b0,
      HALTED = 1'b1
   } ctrlState_e;

   // Per-instruction control levels from the upstream decoder
   typedef struct packed {
      logic lbi;      // Write the immediate instead of writeback
      logic link;     // Write the return address
      logic writeEn;  // Instruction writes a register
      logic bFlag;    // Force the branch path
      logic jFlag;    // Unconditional jump
      logic halt;     // Halting instruction
   } ctrlFlags_t;

   // Register write request from later stages
   typedef struct packed {
      logic [`REG_ADDR_W-1:0] writeAddr;  // Destination register
      logic [`DATA_W-1:0]     writeback;  // Result from execute or memory
   } regWrite_t;

endpackage

// ==== logic/haltControl.sv ====
// **************************************************
// Run/halt state machine that enables the PC and
// register writes
// **************************************************
module haltControl (
   input  logic clk,
   input  logic rst,
   input  logic halt,     // Halt flag of the instruction in decode
   output logic running,  // Counter and register writes enabled
   output logic halted    // Processor stopped
);

   decode_pkg::ctrlState_e state;
   decode_pkg::ctrlState_e nextState;

   // HALTED has no way out except reset
   always_comb begin
      nextState = state;
      case (state)
         decode_pkg::RUN:    if (halt) nextState = decode_pkg::HALTED;
         decode_pkg::HALTED: nextState = decode_pkg::HALTED;
         default:            nextState = decode_pkg::RUN;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= decode_pkg::RUN;
      end else begin
         state <= nextState;
      end
   end

   // Still running during the halting instruction itself, so its write lands
   assign running = (state == decode_pkg::RUN);
   assign halted  = (state == decode_pkg::HALTED);

endmodule

// ==== logic/pcCounter.sv ====
// **************************************************
// Program counter that steps or loads the branch
// target and holds while halted
// **************************************************
`include "decode_params.svh"

module pcCounter (
   input  logic               clk,
   input  logic               rst,
   input  logic               running,       // Counter advances only in RUN
   input  logic               pcSel,         // Take the branch target
   input  logic [`DATA_W-1:0] branchTarget,
   output logic [`DATA_W-1:0] pc
);

   logic [`DATA_W-1:0] nextPc;

   // Redirect or fall through to the next word
   always_comb begin
      if (pcSel) begin
         nextPc = branchTarget;
      end else begin
         nextPc = pc + `DATA_W'(`PC_STEP);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= `DATA_W'(`RESET_PC);
      end else if (running) begin
         pc <= nextPc;
      end
      // Otherwise pc holds its value
   end

endmodule

// ==== logic/regFile.sv ====
// **************************************************
// Eight-entry register file with two combinational
// read ports and one synchronous write port
// **************************************************
`include "decode_params.svh"

module regFile (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`REG_ADDR_W-1:0] readAddr1,  // First source, Rs
   input  logic [`REG_ADDR_W-1:0] readAddr2,  // Second source, Rt
   input  logic                   writeEn,    // Already gated by the run state
   input  logic [`REG_ADDR_W-1:0] writeAddr,
   input  logic [`DATA_W-1:0]     writeData,
   output logic [`DATA_W-1:0]     readData1,
   output logic [`DATA_W-1:0]     readData2
);

   // Register storage
   logic [`DATA_W-1:0] regs [`NUM_REGS];

   // Reset clears every entry
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeAddr] <= writeData;  // Seen by reads from the next cycle on
      end
   end

   // No write-to-read bypass
   // A value written at an edge shows up on the ports after that edge
   assign readData1 = regs[readAddr1];
   assign readData2 = regs[readAddr2];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the decode testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module decode_tb -f compile.f; then
   echo "Verilator build failed"
   exit 1
fi

simOut=$(./obj_dir/Vdecode_tb 2>&1)
simStatus=$?
echo "$simOut"
if [ "$simStatus" -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -qF "All tests passed!" <<< "$simOut"; then
   exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
